//--- source/dcache_pkg.sv
// Data cache geometry, address field widths and the memory operation encoding

package dcache_pkg;

    // Word and address widths seen by the load/store unit
    localparam int DATA_WIDTH = 32;
    localparam int ADDR_WIDTH = 32;

    // Cache geometry, direct mapped
    localparam int CACHE_SIZE = 1024;
    localparam int LINE_SIZE  = 32;
    localparam int LINE_WIDTH = LINE_SIZE * 8;
    localparam int LINE_COUNT = CACHE_SIZE / LINE_SIZE;

    // Address is split as tag | index | offset
    localparam int OFFSET_WIDTH = $clog2(LINE_SIZE);
    localparam int INDEX_WIDTH  = $clog2(LINE_COUNT);
    localparam int TAG_WIDTH    = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH;

    // Bytes per word, which is also the byte select width
    localparam int BYTE_COUNT = DATA_WIDTH / 8;

    // The offset splits again into a word select and a byte lane within the word
    localparam int LANE_WIDTH     = $clog2(BYTE_COUNT);
    localparam int WORD_SEL_WIDTH = OFFSET_WIDTH - LANE_WIDTH;

    // Memory operations, the last three are the stores
    typedef enum logic [2:0] {
        OP_LB  = 3'd0,
        OP_LH  = 3'd1,
        OP_LW  = 3'd2,
        OP_LBU = 3'd3,
        OP_LHU = 3'd4,
        OP_SB  = 3'd5,
        OP_SH  = 3'd6,
        OP_SW  = 3'd7
    } dcache_op_t;

endpackage

//--- source/dcache_dt.sv
// DT stage of the data cache
// Registers the request, splits the address and lines up store or fill data

`timescale 1ns/1ps

module dcache_dt (
    input  logic                               clk,
    input  logic                               i_arst_n,

    input  logic                               i_en,
    input  logic [dcache_pkg::ADDR_WIDTH-1:0]  i_addr,
    input  dcache_pkg::dcache_op_t             i_op,
    input  logic [dcache_pkg::DATA_WIDTH-1:0]  i_data,
    input  logic                               i_fill,
    input  logic [dcache_pkg::LINE_WIDTH-1:0]  i_fill_data,
    input  logic                               i_valid,
    input  logic                               i_dirty,

    output logic                               o_en,
    output logic                               o_store,
    output logic                               o_signed,
    output logic [dcache_pkg::TAG_WIDTH-1:0]   o_tag,
    output logic [dcache_pkg::INDEX_WIDTH-1:0] o_index,
    output logic [dcache_pkg::OFFSET_WIDTH-1:0] o_offset,
    output logic [dcache_pkg::BYTE_COUNT-1:0]  o_byte_sel,
    output logic [dcache_pkg::DATA_WIDTH-1:0]  o_data,
    output logic                               o_fill,
    output logic [dcache_pkg::LINE_WIDTH-1:0]  o_fill_data,
    output logic                               o_valid,
    output logic                               o_dirty
);

    import dcache_pkg::*;

    logic                  is_store;
    logic                  is_signed;
    logic [BYTE_COUNT-1:0] byte_sel;
    logic [DATA_WIDTH-1:0] aligned_data;

    // A fill ignores the operation, so it never counts as a store
    assign is_store  = !i_fill && (i_op inside {OP_SB, OP_SH, OP_SW});
    assign is_signed = i_op inside {OP_LB, OP_LH};

    // Byte enables sit in the word lane picked by the low address bits.
    // Store data is copied to every lane so DW can merge with the enables alone
    always_comb begin
        case (i_op)
            OP_LB, OP_LBU, OP_SB: begin
                byte_sel     = BYTE_COUNT'(1) << i_addr[LANE_WIDTH-1:0];
                aligned_data = {BYTE_COUNT{i_data[7:0]}};
            end
            OP_LH, OP_LHU, OP_SH: begin
                // Bit 0 is dropped so an odd half address truncates to alignment
                byte_sel     = BYTE_COUNT'(3) << {i_addr[LANE_WIDTH-1], 1'b0};
                aligned_data = {(BYTE_COUNT / 2){i_data[15:0]}};
            end
            default: begin
                byte_sel     = '1;
                aligned_data = i_data;
            end
        endcase
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_en <= 1'b0;
        end else begin
            o_en <= i_en;
        end
    end

    always_ff @(posedge clk) begin
        o_store     <= is_store;
        o_signed    <= is_signed;
        o_tag       <= i_addr[ADDR_WIDTH-1 -: TAG_WIDTH];
        o_index     <= i_addr[OFFSET_WIDTH +: INDEX_WIDTH];
        o_offset    <= i_addr[OFFSET_WIDTH-1:0];
        o_byte_sel  <= byte_sel;
        o_data      <= aligned_data;
        o_fill      <= i_fill;
        o_fill_data <= i_fill_data;
        o_valid     <= i_valid;
        o_dirty     <= i_dirty;
    end

endmodule

//--- source/dcache_store.sv
// Line store for the data cache
// Valid, dirty, tag and data arrays with a registered read and one write port

`timescale 1ns/1ps

module dcache_store (
    input  logic                               clk,
    input  logic                               i_arst_n,

    input  logic [dcache_pkg::INDEX_WIDTH-1:0] i_rd_index,

    input  logic                               i_wr_en,
    input  logic [dcache_pkg::INDEX_WIDTH-1:0] i_wr_index,
    input  logic                               i_wr_valid,
    input  logic                               i_wr_dirty,
    input  logic [dcache_pkg::TAG_WIDTH-1:0]   i_wr_tag,
    input  logic [dcache_pkg::LINE_WIDTH-1:0]  i_wr_data,

    output logic                               o_rd_valid,
    output logic                               o_rd_dirty,
    output logic [dcache_pkg::TAG_WIDTH-1:0]   o_rd_tag,
    output logic [dcache_pkg::LINE_WIDTH-1:0]  o_rd_data
);

    import dcache_pkg::*;

    logic [LINE_COUNT-1:0] valid_q;
    logic [LINE_COUNT-1:0] dirty_q;
    logic [TAG_WIDTH-1:0]  tag_mem  [LINE_COUNT];
    logic [LINE_WIDTH-1:0] data_mem [LINE_COUNT];

    // Line state bits start cleared so every line comes up invalid and clean
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            valid_q    <= '0;
            dirty_q    <= '0;
            o_rd_valid <= 1'b0;
            o_rd_dirty <= 1'b0;
        end else begin
            o_rd_valid <= valid_q[i_rd_index];
            o_rd_dirty <= dirty_q[i_rd_index];
            if (i_wr_en) begin
                valid_q[i_wr_index] <= i_wr_valid;
                dirty_q[i_wr_index] <= i_wr_dirty;
            end
        end
    end

    // Reads sample the arrays before this edge's write lands, giving old contents
    always_ff @(posedge clk) begin
        o_rd_tag  <= tag_mem[i_rd_index];
        o_rd_data <= data_mem[i_rd_index];
        if (i_wr_en) begin
            tag_mem[i_wr_index]  <= i_wr_tag;
            data_mem[i_wr_index] <= i_wr_data;
        end
    end

endmodule

//--- source/dcache_dw.sv
// DW stage of the data cache
// Tag compare, load extraction, store merge, fill write and victim report

`timescale 1ns/1ps

module dcache_dw (
    input  logic                                clk,
    input  logic                                i_arst_n,

    // Request from the DT stage
    input  logic                                i_en,
    input  logic                                i_store,
    input  logic                                i_signed,
    input  logic [dcache_pkg::TAG_WIDTH-1:0]    i_tag,
    input  logic [dcache_pkg::INDEX_WIDTH-1:0]  i_index,
    input  logic [dcache_pkg::OFFSET_WIDTH-1:0] i_offset,
    input  logic [dcache_pkg::BYTE_COUNT-1:0]   i_byte_sel,
    input  logic [dcache_pkg::DATA_WIDTH-1:0]   i_data,
    input  logic                                i_fill,
    input  logic [dcache_pkg::LINE_WIDTH-1:0]   i_fill_data,
    input  logic                                i_valid,
    input  logic                                i_dirty,

    // Registered read from the line store
    input  logic                                i_rd_valid,
    input  logic                                i_rd_dirty,
    input  logic [dcache_pkg::TAG_WIDTH-1:0]    i_rd_tag,
    input  logic [dcache_pkg::LINE_WIDTH-1:0]   i_rd_data,

    // Store write port fed back for forwarding
    input  logic                                i_byp_wr_en,
    input  logic [dcache_pkg::INDEX_WIDTH-1:0]  i_byp_wr_index,
    input  logic                                i_byp_wr_valid,
    input  logic                                i_byp_wr_dirty,
    input  logic [dcache_pkg::TAG_WIDTH-1:0]    i_byp_wr_tag,
    input  logic [dcache_pkg::LINE_WIDTH-1:0]   i_byp_wr_data,

    output logic                                o_wr_en,
    output logic [dcache_pkg::INDEX_WIDTH-1:0]  o_wr_index,
    output logic                                o_wr_valid,
    output logic                                o_wr_dirty,
    output logic [dcache_pkg::TAG_WIDTH-1:0]    o_wr_tag,
    output logic [dcache_pkg::LINE_WIDTH-1:0]   o_wr_data,

    output logic                                o_done,
    output logic                                o_hit,
    output logic [dcache_pkg::DATA_WIDTH-1:0]   o_data,
    output logic                                o_victim_valid,
    output logic [dcache_pkg::ADDR_WIDTH-1:0]   o_victim_addr,
    output logic [dcache_pkg::LINE_WIDTH-1:0]   o_victim_data
);

    import dcache_pkg::*;

    logic                      byp_en_q;
    logic [INDEX_WIDTH-1:0]    byp_index_q;
    logic                      byp_valid_q;
    logic                      byp_dirty_q;
    logic [TAG_WIDTH-1:0]      byp_tag_q;
    logic [LINE_WIDTH-1:0]     byp_data_q;

    logic                      use_byp;
    logic                      line_valid;
    logic                      line_dirty;
    logic [TAG_WIDTH-1:0]      line_tag;
    logic [LINE_WIDTH-1:0]     line_data;

    logic                      tag_hit;
    logic [WORD_SEL_WIDTH-1:0] word_sel;
    logic [DATA_WIDTH-1:0]     load_word;
    logic [LANE_WIDTH-1:0]     lane;
    logic [DATA_WIDTH-1:0]     lane_word;
    logic [DATA_WIDTH-1:0]     load_ext;
    logic [LINE_WIDTH-1:0]     merged_line;

    // The write that lands at the edge of this request's store read is not in
    // the read data, so keep a copy of it for one cycle
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            byp_en_q <= 1'b0;
        end else begin
            byp_en_q <= i_byp_wr_en;
        end
    end

    always_ff @(posedge clk) begin
        byp_index_q <= i_byp_wr_index;
        byp_valid_q <= i_byp_wr_valid;
        byp_dirty_q <= i_byp_wr_dirty;
        byp_tag_q   <= i_byp_wr_tag;
        byp_data_q  <= i_byp_wr_data;
    end

    assign use_byp    = byp_en_q && (byp_index_q == i_index);
    assign line_valid = use_byp ? byp_valid_q : i_rd_valid;
    assign line_dirty = use_byp ? byp_dirty_q : i_rd_dirty;
    assign line_tag   = use_byp ? byp_tag_q   : i_rd_tag;
    assign line_data  = use_byp ? byp_data_q  : i_rd_data;

    assign tag_hit  = line_valid && (line_tag == i_tag);
    assign word_sel = i_offset[OFFSET_WIDTH-1:LANE_WIDTH];

    assign load_word = line_data[word_sel*DATA_WIDTH +: DATA_WIDTH];

    // The lowest enabled byte gives the lane the load starts at
    always_comb begin
        lane = '0;
        for (int b = BYTE_COUNT - 1; b >= 0; b--) begin
            if (i_byte_sel[b]) begin
                lane = LANE_WIDTH'(b);
            end
        end
    end

    assign lane_word = load_word >> {lane, 3'b000};

    always_comb begin
        case (i_byte_sel)
            4'b1111: load_ext = lane_word;
            4'b0011, 4'b1100: begin
                load_ext = {{(DATA_WIDTH - 16){i_signed & lane_word[15]}}, lane_word[15:0]};
            end
            default: begin
                load_ext = {{(DATA_WIDTH - 8){i_signed & lane_word[7]}}, lane_word[7:0]};
            end
        endcase
    end

    // Store data is already copied to every lane, the enables pick the bytes
    always_comb begin
        merged_line = line_data;
        for (int i = 0; i < LINE_SIZE; i++) begin
            if ((WORD_SEL_WIDTH'(i / BYTE_COUNT) == word_sel) && i_byte_sel[i % BYTE_COUNT]) begin
                merged_line[i*8 +: 8] = i_data[(i % BYTE_COUNT)*8 +: 8];
            end
        end
    end

    // Only a fill or a store hit changes the line, a store miss writes nothing
    assign o_wr_en    = i_en && (i_fill || (i_store && tag_hit));
    assign o_wr_index = i_index;
    assign o_wr_valid = i_fill ? i_valid : line_valid;
    assign o_wr_dirty = i_fill ? i_dirty : 1'b1;
    assign o_wr_tag   = i_fill ? i_tag : line_tag;
    assign o_wr_data  = i_fill ? i_fill_data : merged_line;

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_done         <= 1'b0;
            o_hit          <= 1'b0;
            o_victim_valid <= 1'b0;
        end else begin
            o_done         <= i_en;
            o_hit          <= i_en && (i_fill || tag_hit);
            o_victim_valid <= i_en && i_fill && line_valid && line_dirty;
        end
    end

    // Only a load that hits returns data, everything else gives zero
    always_ff @(posedge clk) begin
        o_data        <= (tag_hit && !i_store && !i_fill) ? load_ext : '0;
        o_victim_addr <= {line_tag, i_index, {OFFSET_WIDTH{1'b0}}};
        o_victim_data <= line_data;
    end

endmodule

//--- source/dcache.sv
// Data cache top level
// Connects the DT stage, the DW stage and the line store

`timescale 1ns/1ps

module dcache (
    input  logic                               clk,
    input  logic                               i_arst_n,

    input  logic                               i_dc_en,
    input  logic [dcache_pkg::ADDR_WIDTH-1:0]  i_dc_addr,
    input  dcache_pkg::dcache_op_t             i_dc_op,
    input  logic [dcache_pkg::DATA_WIDTH-1:0]  i_dc_data,
    input  logic                               i_dc_fill,
    input  logic [dcache_pkg::LINE_WIDTH-1:0]  i_dc_fill_data,
    input  logic                               i_dc_valid,
    input  logic                               i_dc_dirty,

    output logic                               o_dc_done,
    output logic                               o_dc_hit,
    output logic [dcache_pkg::DATA_WIDTH-1:0]  o_dc_data,
    output logic                               o_dc_victim_valid,
    output logic [dcache_pkg::ADDR_WIDTH-1:0]  o_dc_victim_addr,
    output logic [dcache_pkg::LINE_WIDTH-1:0]  o_dc_victim_data
);

    import dcache_pkg::*;

    logic [INDEX_WIDTH-1:0]  rd_index;

    logic                    dt_en;
    logic                    dt_store;
    logic                    dt_signed;
    logic [TAG_WIDTH-1:0]    dt_tag;
    logic [INDEX_WIDTH-1:0]  dt_index;
    logic [OFFSET_WIDTH-1:0] dt_offset;
    logic [BYTE_COUNT-1:0]   dt_byte_sel;
    logic [DATA_WIDTH-1:0]   dt_data;
    logic                    dt_fill;
    logic [LINE_WIDTH-1:0]   dt_fill_data;
    logic                    dt_valid;
    logic                    dt_dirty;

    logic                    rd_valid;
    logic                    rd_dirty;
    logic [TAG_WIDTH-1:0]    rd_tag;
    logic [LINE_WIDTH-1:0]   rd_data;

    logic                    wr_en;
    logic [INDEX_WIDTH-1:0]  wr_index;
    logic                    wr_valid;
    logic                    wr_dirty;
    logic [TAG_WIDTH-1:0]    wr_tag;
    logic [LINE_WIDTH-1:0]   wr_data;

    // The store is read in the same cycle DT latches the request
    assign rd_index = i_dc_addr[OFFSET_WIDTH +: INDEX_WIDTH];

    dcache_dt u_dt (
        .clk         (clk),
        .i_arst_n    (i_arst_n),
        .i_en        (i_dc_en),
        .i_addr      (i_dc_addr),
        .i_op        (i_dc_op),
        .i_data      (i_dc_data),
        .i_fill      (i_dc_fill),
        .i_fill_data (i_dc_fill_data),
        .i_valid     (i_dc_valid),
        .i_dirty     (i_dc_dirty),
        .o_en        (dt_en),
        .o_store     (dt_store),
        .o_signed    (dt_signed),
        .o_tag       (dt_tag),
        .o_index     (dt_index),
        .o_offset    (dt_offset),
        .o_byte_sel  (dt_byte_sel),
        .o_data      (dt_data),
        .o_fill      (dt_fill),
        .o_fill_data (dt_fill_data),
        .o_valid     (dt_valid),
        .o_dirty     (dt_dirty)
    );

    dcache_dw u_dw (
        .clk            (clk),
        .i_arst_n       (i_arst_n),
        .i_en           (dt_en),
        .i_store        (dt_store),
        .i_signed       (dt_signed),
        .i_tag          (dt_tag),
        .i_index        (dt_index),
        .i_offset       (dt_offset),
        .i_byte_sel     (dt_byte_sel),
        .i_data         (dt_data),
        .i_fill         (dt_fill),
        .i_fill_data    (dt_fill_data),
        .i_valid        (dt_valid),
        .i_dirty        (dt_dirty),
        .i_rd_valid     (rd_valid),
        .i_rd_dirty     (rd_dirty),
        .i_rd_tag       (rd_tag),
        .i_rd_data      (rd_data),
        .i_byp_wr_en    (wr_en),
        .i_byp_wr_index (wr_index),
        .i_byp_wr_valid (wr_valid),
        .i_byp_wr_dirty (wr_dirty),
        .i_byp_wr_tag   (wr_tag),
        .i_byp_wr_data  (wr_data),
        .o_wr_en        (wr_en),
        .o_wr_index     (wr_index),
        .o_wr_valid     (wr_valid),
        .o_wr_dirty     (wr_dirty),
        .o_wr_tag       (wr_tag),
        .o_wr_data      (wr_data),
        .o_done         (o_dc_done),
        .o_hit          (o_dc_hit),
        .o_data         (o_dc_data),
        .o_victim_valid (o_dc_victim_valid),
        .o_victim_addr  (o_dc_victim_addr),
        .o_victim_data  (o_dc_victim_data)
    );

    dcache_store u_store (
        .clk        (clk),
        .i_arst_n   (i_arst_n),
        .i_rd_index (rd_index),
        .i_wr_en    (wr_en),
        .i_wr_index (wr_index),
        .i_wr_valid (wr_valid),
        .i_wr_dirty (wr_dirty),
        .i_wr_tag   (wr_tag),
        .i_wr_data  (wr_data),
        .o_rd_valid (rd_valid),
        .o_rd_dirty (rd_dirty),
        .o_rd_tag   (rd_tag),
        .o_rd_data  (rd_data)
    );

endmodule

//--- tb/dcache_checker.sv
// Result checker for the data cache testbench
// Holds the expected golden columns and compares every completed request

`timescale 1ns/1ps

module dcache_checker (
    input  logic                              clk,
    input  logic                              i_done,
    input  logic                              i_hit,
    input  logic [dcache_pkg::DATA_WIDTH-1:0] i_data,
    input  logic                              i_victim_valid,
    input  logic [dcache_pkg::ADDR_WIDTH-1:0] i_victim_addr,
    input  logic [dcache_pkg::LINE_WIDTH-1:0] i_victim_data,
    input  logic                              i_end,
    output int                                o_received,
    output int                                o_value_errors,
    output int                                o_missing,
    output int                                o_extra
);

    import dcache_pkg::*;

    logic                  exp_hit [$];
    logic [DATA_WIDTH-1:0] exp_data [$];
    logic                  exp_victim [$];
    logic [ADDR_WIDTH-1:0] exp_victim_addr [$];
    logic [LINE_WIDTH-1:0] exp_victim_line [$];

    task automatic compare_field(input string name, input logic [LINE_WIDTH-1:0] got,
                                 input logic [LINE_WIDTH-1:0] expected);
        if (got !== expected) begin
            o_value_errors++;
            $display("[ERROR] %0t: request %0d, %0s is %0h, expected %0h",
                     $time, o_received, name, got, expected);
        end
    endtask

    initial begin : read_expected
        int                    fd;
        int                    n;
        string                 line;
        string                 op_name;
        logic [ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0] data;
        int                    valid;
        int                    dirty;
        logic [LINE_WIDTH-1:0] fill_line;
        int                    hit;
        logic [DATA_WIDTH-1:0] load;
        int                    victim;
        logic [ADDR_WIDTH-1:0] victim_addr;
        logic [LINE_WIDTH-1:0] victim_line;
        $timeformat(-9, 0, " ns", 0);
        o_received     = 0;
        o_value_errors = 0;
        o_missing      = 0;
        o_extra        = 0;
        fd = $fopen("tb/dcache_golden.txt", "r");
        if (fd == 0) begin
            $display("Checker could not open tb/dcache_golden.txt");
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 2 && line.substr(0, 1) != "//") begin
                    n = $sscanf(line, "%s %h %h %d %d %h %d %h %d %h %h",
                                op_name, addr, data, valid, dirty, fill_line,
                                hit, load, victim, victim_addr, victim_line);
                    // Only the expected columns are kept here
                    if (n == 11) begin
                        exp_hit.push_back(hit != 0);
                        exp_data.push_back(load);
                        exp_victim.push_back(victim != 0);
                        exp_victim_addr.push_back(victim_addr);
                        exp_victim_line.push_back(victim_line);
                    end
                end
            end
            $fclose(fd);
        end
    end

    // Victim address and line only mean something while victim valid is expected
    always @(posedge clk) begin
        if (i_done) begin
            if (o_received < exp_hit.size()) begin
                compare_field("hit", i_hit, exp_hit[o_received]);
                compare_field("load data", i_data, exp_data[o_received]);
                compare_field("victim valid", i_victim_valid, exp_victim[o_received]);
                if (exp_victim[o_received]) begin
                    compare_field("victim address", i_victim_addr, exp_victim_addr[o_received]);
                    compare_field("victim line", i_victim_data, exp_victim_line[o_received]);
                end
                o_received++;
            end else begin
                o_extra++;
            end
        end
    end

    always @(posedge i_end) begin
        o_missing = exp_hit.size() - o_received;
        if (o_missing > 0) begin
            $display("%0d expected results never arrived", o_missing);
        end
        if (o_extra > 0) begin
            $display("%0d results arrived after every expected result was used", o_extra);
        end
    end

endmodule

//--- tb/dcache_tb.sv
// Testbench top for the data cache
// Clock, reset, golden-file stimulus with LFSR gaps, watchdog and final report

`timescale 1ns/1ps

module dcache_tb;

    import dcache_pkg::*;

    localparam time CLK_PERIOD = 40;

    logic                  clk;
    logic                  i_arst_n;
    logic                  i_dc_en;
    logic [ADDR_WIDTH-1:0] i_dc_addr;
    dcache_op_t            i_dc_op;
    logic [DATA_WIDTH-1:0] i_dc_data;
    logic                  i_dc_fill;
    logic [LINE_WIDTH-1:0] i_dc_fill_data;
    logic                  i_dc_valid;
    logic                  i_dc_dirty;

    logic                  o_dc_done;
    logic                  o_dc_hit;
    logic [DATA_WIDTH-1:0] o_dc_data;
    logic                  o_dc_victim_valid;
    logic [ADDR_WIDTH-1:0] o_dc_victim_addr;
    logic [LINE_WIDTH-1:0] o_dc_victim_data;

    // Stimulus columns of the golden file hold one entry per request
    logic [ADDR_WIDTH-1:0] vec_addr [$];
    dcache_op_t            vec_op [$];
    logic [DATA_WIDTH-1:0] vec_data [$];
    logic                  vec_fill [$];
    logic                  vec_valid [$];
    logic                  vec_dirty [$];
    logic [LINE_WIDTH-1:0] vec_line [$];

    int                    vec_count;
    int                    parse_errors;
    logic                  vectors_loaded;
    logic                  check_end;
    logic [31:0]           lfsr_state;

    int                    received;
    int                    value_errors;
    int                    missing;
    int                    extra;

    function automatic dcache_op_t decode_op(input string name);
        dcache_op_t op;
        op = OP_LW;
        if (name == "LB") op = OP_LB;
        else if (name == "LH") op = OP_LH;
        else if (name == "LBU") op = OP_LBU;
        else if (name == "LHU") op = OP_LHU;
        else if (name == "SB") op = OP_SB;
        else if (name == "SH") op = OP_SH;
        else if (name == "SW") op = OP_SW;
        return op;
    endfunction

    // Taps 32, 22, 2 and 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    task automatic take_random_bit(output logic b);
        lfsr_state = lfsr_next(lfsr_state);
        b = lfsr_state[0];
    endtask

    task automatic read_vectors();
        int                    fd;
        int                    n;
        string                 line;
        string                 op_name;
        logic [ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0] data;
        int                    valid;
        int                    dirty;
        logic [LINE_WIDTH-1:0] fill_line;
        fd = $fopen("tb/dcache_golden.txt", "r");
        if (fd == 0) begin
            $display("Could not open tb/dcache_golden.txt");
            parse_errors++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 2 && line.substr(0, 1) != "//") begin
                    n = $sscanf(line, "%s %h %h %d %d %h",
                                op_name, addr, data, valid, dirty, fill_line);
                    if (n == 6) begin
                        vec_addr.push_back(addr);
                        vec_op.push_back(decode_op(op_name));
                        vec_fill.push_back(op_name == "FL");
                        vec_data.push_back(data);
                        vec_valid.push_back(valid != 0);
                        vec_dirty.push_back(dirty != 0);
                        vec_line.push_back(fill_line);
                    end else begin
                        $display("Golden line could not be read: %0s", line);
                        parse_errors++;
                    end
                end
            end
            $fclose(fd);
        end
        vec_count = vec_addr.size();
    endtask

    initial begin : clock_gen
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    dcache dut (
        .clk               (clk),
        .i_arst_n          (i_arst_n),
        .i_dc_en           (i_dc_en),
        .i_dc_addr         (i_dc_addr),
        .i_dc_op           (i_dc_op),
        .i_dc_data         (i_dc_data),
        .i_dc_fill         (i_dc_fill),
        .i_dc_fill_data    (i_dc_fill_data),
        .i_dc_valid        (i_dc_valid),
        .i_dc_dirty        (i_dc_dirty),
        .o_dc_done         (o_dc_done),
        .o_dc_hit          (o_dc_hit),
        .o_dc_data         (o_dc_data),
        .o_dc_victim_valid (o_dc_victim_valid),
        .o_dc_victim_addr  (o_dc_victim_addr),
        .o_dc_victim_data  (o_dc_victim_data)
    );

    dcache_checker u_checker (
        .clk            (clk),
        .i_done         (o_dc_done),
        .i_hit          (o_dc_hit),
        .i_data         (o_dc_data),
        .i_victim_valid (o_dc_victim_valid),
        .i_victim_addr  (o_dc_victim_addr),
        .i_victim_data  (o_dc_victim_data),
        .i_end          (check_end),
        .o_received     (received),
        .o_value_errors (value_errors),
        .o_missing      (missing),
        .o_extra        (extra)
    );

    initial begin : stimulus
        logic b0;
        logic b1;
        int   gap;
        int   drain;
        i_arst_n       = 1'b0;
        i_dc_en        = 1'b0;
        i_dc_addr      = '0;
        i_dc_op        = OP_LW;
        i_dc_data      = '0;
        i_dc_fill      = 1'b0;
        i_dc_fill_data = '0;
        i_dc_valid     = 1'b0;
        i_dc_dirty     = 1'b0;
        check_end      = 1'b0;
        vectors_loaded = 1'b0;
        parse_errors   = 0;
        lfsr_state     = 32'h31c48df7;
        read_vectors();
        vectors_loaded = 1'b1;

        repeat (8) @(posedge clk);
        i_arst_n <= 1'b1;

        for (int v = 0; v < vec_count; v++) begin
            @(posedge clk);
            i_dc_en        <= 1'b1;
            i_dc_addr      <= vec_addr[v];
            i_dc_op        <= vec_op[v];
            i_dc_data      <= vec_data[v];
            i_dc_fill      <= vec_fill[v];
            i_dc_fill_data <= vec_line[v];
            i_dc_valid     <= vec_valid[v];
            i_dc_dirty     <= vec_dirty[v];
            // Zero to three idle cycles follow, so a zero gap sends the next request back to back
            take_random_bit(b0);
            take_random_bit(b1);
            gap = {b1, b0};
            repeat (gap) begin
                @(posedge clk);
                i_dc_en <= 1'b0;
            end
        end
        @(posedge clk);
        i_dc_en <= 1'b0;

        // The last result is due two edges after its request
        drain = 0;
        while (received < vec_count && drain < 4) begin
            @(posedge clk);
            drain++;
        end
        // A few more edges so that a stray done pulse is still seen
        repeat (3) @(posedge clk);
        check_end = 1'b1;
        @(posedge clk);

        $display("Errors: %0d value mismatches, %0d missing, %0d unexpected, %0d unreadable lines",
                 value_errors, missing, extra, parse_errors);
        if (value_errors + missing + extra + parse_errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    initial begin : watchdog
        wait (vectors_loaded);
        repeat (vec_count * 6 + 20) @(posedge clk);
        $display("Timeout: the run did not complete within %0d clock cycles",
                 vec_count * 6 + 20);
        $display("Some tests failed");
        $finish;
    end

endmodule

//--- dcache.f
source/dcache_pkg.sv
source/dcache_dt.sv
source/dcache_store.sv
source/dcache_dw.sv
source/dcache.sv
tb/dcache_checker.sv
tb/dcache_tb.sv

//--- Bender.yml
package:
  name: dcache

sources:
  - source/dcache_pkg.sv
  - source/dcache_dt.sv
  - source/dcache_store.sv
  - source/dcache_dw.sv
  - source/dcache.sv
  - target: test
    files:
      - tb/dcache_checker.sv
      - tb/dcache_tb.sv

//--- tb/dcache_golden.txt
// op addr store_data fill_valid fill_dirty fill_line hit load_data victim_valid victim_addr victim_line
// FL is a fill, unused fields are 0, wide lines are 64 hex digits with word 7 first
LW  00002000 00000000 0 0 0 0 00000000 0 00000000 0
LB  00001044 00000000 0 0 0 0 00000000 0 00000000 0
FL  00001040 00000000 1 0 cafe12347f80017e0badf00dddeeff0099aabbcc55667788112233448377f102 1 00000000 0 00000000 0
LW  00001040 00000000 0 0 0 1 8377f102 0 00000000 0
LB  00001040 00000000 0 0 0 1 00000002 0 00000000 0
LB  00001043 00000000 0 0 0 1 ffffff83 0 00000000 0
LBU 00001043 00000000 0 0 0 1 00000083 0 00000000 0
LH  00001042 00000000 0 0 0 1 ffff8377 0 00000000 0
LHU 00001042 00000000 0 0 0 1 00008377 0 00000000 0
LH  00001040 00000000 0 0 0 1 fffff102 0 00000000 0
LB  00001059 00000000 0 0 0 1 00000001 0 00000000 0
LB  0000105a 00000000 0 0 0 1 ffffff80 0 00000000 0
LHU 0000105a 00000000 0 0 0 1 00007f80 0 00000000 0
LW  0000105c 00000000 0 0 0 1 cafe1234 0 00000000 0
SB  00001045 000000a5 0 0 0 1 00000000 0 00000000 0
LW  00001044 00000000 0 0 0 1 1122a544 0 00000000 0
SH  0000104a 0000beef 0 0 0 1 00000000 0 00000000 0
LW  00001048 00000000 0 0 0 1 beef7788 0 00000000 0
LH  0000104a 00000000 0 0 0 1 ffffbeef 0 00000000 0
SW  0000104c 01234567 0 0 0 1 00000000 0 00000000 0
LW  0000104c 00000000 0 0 0 1 01234567 0 00000000 0
LW  00001040 00000000 0 0 0 1 8377f102 0 00000000 0
SW  00001440 deadbeef 0 0 0 0 00000000 0 00000000 0
LW  00001440 00000000 0 0 0 0 00000000 0 00000000 0
LW  00001040 00000000 0 0 0 1 8377f102 0 00000000 0
FL  00001440 00000000 1 0 07070707060606060505050504040404030303030202020201010101f0e0d0c0 1 00000000 1 00001040 cafe12347f80017e0badf00dddeeff0001234567beef77881122a5448377f102
LW  00001440 00000000 0 0 0 1 f0e0d0c0 0 00000000 0
LW  00001040 00000000 0 0 0 0 00000000 0 00000000 0
LB  00001441 00000000 0 0 0 1 ffffffd0 0 00000000 0
FL  00001040 00000000 1 0 cafe12347f80017e0badf00dddeeff0099aabbcc55667788112233448377f102 1 00000000 0 00000000 0
LW  00001044 00000000 0 0 0 1 11223344 0 00000000 0
LW  00001440 00000000 0 0 0 0 00000000 0 00000000 0
FL  000010e0 00000000 1 1 07070707060606060505050504040404030303030202020201010101f0e0d0c0 1 00000000 0 00000000 0
LW  000010e4 00000000 0 0 0 1 01010101 0 00000000 0
SB  000010e0 000000ff 0 0 0 1 00000000 0 00000000 0
FL  000014e0 00000000 1 0 cafe12347f80017e0badf00dddeeff0099aabbcc55667788112233448377f102 1 00000000 1 000010e0 07070707060606060505050504040404030303030202020201010101f0e0d0ff
LW  000014e0 00000000 0 0 0 1 8377f102 0 00000000 0
LBU 000010e3 00000000 0 0 0 0 00000000 0 00000000 0
FL  00001120 00000000 0 0 cafe12347f80017e0badf00dddeeff0099aabbcc55667788112233448377f102 1 00000000 0 00000000 0
LW  00001120 00000000 0 0 0 0 00000000 0 00000000 0
